// ==== design/warp_core_settings.svh ====
// Core size macros: lanes per warp, warps per core, data width, warp number width
`ifndef WARP_CORE_SETTINGS_SVH
`define WARP_CORE_SETTINGS_SVH

// Lanes per warp, fits a one-word thread mask
`define NUM_THREADS 4

// Warps per core
`define NUM_WARPS 4

// RV32 data path
`define XLEN 32

// Warp number width, at least one bit
`define WARP_W (($clog2(`NUM_WARPS) > 0) ? $clog2(`NUM_WARPS) : 1)

`endif

// ==== design/isa_pkg.sv ====
// ISA encodings: major opcodes, ALU operations, branch kinds, write-back source, GPGPU kinds
package isa_pkg;

	// Major opcodes, bits [6:0] of the instruction
	typedef enum logic [6:0] {
		OP_R       = 7'b0110011,
		OP_IMM     = 7'b0010011,
		OP_LOAD    = 7'b0000011,
		OP_STORE   = 7'b0100011,
		OP_BRANCH  = 7'b1100011,
		OP_JAL     = 7'b1101111,
		OP_JALR    = 7'b1100111,
		OP_LUI     = 7'b0110111,
		OP_AUIPC   = 7'b0010111,
		OP_SYSTEM  = 7'b1110011,
		OP_GPGPU   = 7'b1101011,
		OP_ILLEGAL = 7'b0000000
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_LUI,
		ALU_AUIPC,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_NONE
	} branch_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_src_e;

	// Values match func3 of the GPGPU opcode
	typedef enum logic [2:0] {
		GP_TMC     = 3'd0,
		GP_WSPAWN  = 3'd1,
		GP_SPLIT   = 3'd2,
		GP_JOIN    = 3'd3,
		GP_BARRIER = 3'd4,
		GP_NONE    = 3'd7
	} gpgpu_e;

endpackage

// ==== design/pipe_pkg.sv ====
// Records passed between the pipeline stages and to the outside
`include "warp_core_settings.svh"

package pipe_pkg;
	import isa_pkg::*;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`NUM_THREADS-1:0] tmask_t;
	typedef logic [`WARP_W-1:0] warp_t;
	typedef logic [`NUM_THREADS-1:0][`XLEN-1:0] lane_words_t;

	typedef struct packed {
		word_t  instr;
		word_t  pc;
		warp_t  warp;
		tmask_t mask;
	} inst_meta_t;

	typedef struct packed {
		lane_words_t rs1;
		lane_words_t rs2;
	} operand_t;

	typedef struct packed {
		word_t      pc;
		word_t      next_pc;
		warp_t      warp;
		tmask_t     mask;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		alu_op_e    alu_op;
		branch_e    branch;
		logic       jump;
		logic       jalr;
		logic       imm_sel;
		word_t      imm;
		wb_src_e    wb_src;
		logic       is_load;
		logic       is_store;
		logic [2:0] mem_func3;
		gpgpu_e     gpgpu;
		logic       illegal;
	} decode_req_t;

	typedef struct packed {
		word_t       next_pc;
		warp_t       warp;
		tmask_t      mask;
		logic [4:0]  rd;
		branch_e     branch;
		logic        jump;
		wb_src_e     wb_src;
		gpgpu_e      gpgpu;
		logic        illegal;
		lane_words_t alu_res;
		logic        taken;
		word_t       target;
		// rs1 of the lowest active lane
		word_t       lead_opnd;
	} exec_req_t;

	typedef struct packed {
		warp_t       warp;
		logic [4:0]  rd;
		lane_words_t data;
		tmask_t      wmask;
	} wb_t;

	typedef struct packed {
		warp_t warp;
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		warp_t  warp;
		gpgpu_e kind;
		tmask_t mask;
		word_t  opnd;
	} warp_ctrl_t;

endpackage

// ==== design/inst_decode.sv ====
// Decode stage: instruction split into a request record, warp stall and join strobes
`timescale 1ns/1ps
`include "warp_core_settings.svh"

module inst_decode
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        in_stb,
	input  inst_meta_t  in_meta,
	input  operand_t    in_ops,
	output logic        dec_stb,
	output decode_req_t dec_req,
	output operand_t    dec_ops,
	output logic        wstall_stb,
	output warp_t       wstall_warp,
	output logic        join_stb,
	output warp_t       join_warp
);

	word_t       instr;
	logic [2:0]  func3;
	logic [6:0]  func7;
	opcode_e     opc;
	alu_op_e     funct_alu;
	branch_e     br_kind;
	gpgpu_e      gp_kind;
	logic        r_ok;
	logic        shift_imm;
	word_t       imm_c;
	decode_req_t req;
	logic        has_lanes;
	logic        stall_c;
	logic        join_c;

	assign instr     = in_meta.instr;
	assign func3     = instr[14:12];
	assign func7     = instr[31:25];
	assign has_lanes = |in_meta.mask;
	assign shift_imm = (func3 == 3'd1) || (func3 == 3'd5);

	// SYSTEM (CSR, ecall, ebreak) falls out as illegal
	always_comb
	begin
		case (instr[6:0])
			OP_R, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_JALR,
			OP_LUI, OP_AUIPC, OP_GPGPU: opc = opcode_e'(instr[6:0]);
			default: opc = OP_ILLEGAL;
		endcase
	end

	// Register and immediate ALU forms share func3 decoding
	always_comb
	begin
		case (func3)
			3'd0: funct_alu = ((opc == OP_R) && func7[5]) ? ALU_SUB : ALU_ADD;
			3'd1: funct_alu = ALU_SLL;
			3'd2: funct_alu = ALU_SLT;
			3'd3: funct_alu = ALU_SLTU;
			3'd4: funct_alu = ALU_XOR;
			3'd5: funct_alu = func7[5] ? ALU_SRA : ALU_SRL;
			3'd6: funct_alu = ALU_OR;
			default: funct_alu = ALU_AND;
		endcase
	end

	// No mul/div: only base func7 encodings
	assign r_ok = (func7 == 7'h00) || ((func7 == 7'h20) && ((func3 == 3'd0) || (func3 == 3'd5)));

	always_comb
	begin
		case (func3)
			3'd0: br_kind = BR_BEQ;
			3'd1: br_kind = BR_BNE;
			3'd4: br_kind = BR_BLT;
			3'd5: br_kind = BR_BGE;
			3'd6: br_kind = BR_BLTU;
			3'd7: br_kind = BR_BGEU;
			default: br_kind = BR_NONE;
		endcase
	end

	assign gp_kind = (func3 <= 3'd4) ? gpgpu_e'(func3) : GP_NONE;

	always_comb
	begin
		case (opc)
			OP_IMM: imm_c = shift_imm ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
			OP_LOAD, OP_JALR: imm_c = {{20{instr[31]}}, instr[31:20]};
			OP_STORE: imm_c = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			OP_BRANCH: imm_c = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			OP_LUI, OP_AUIPC: imm_c = {instr[31:12], 12'b0};
			OP_JAL: imm_c = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm_c = '0;
		endcase
	end

	always_comb
	begin
		req = '0;
		req.pc = in_meta.pc;
		req.next_pc = in_meta.pc + 32'd4;
		req.warp = in_meta.warp;
		req.mask = in_meta.mask;
		req.rd = instr[11:7];
		req.rs1 = instr[19:15];
		req.rs2 = instr[24:20];
		req.imm = imm_c;
		req.alu_op = ALU_NONE;
		req.branch = BR_NONE;
		req.wb_src = WB_NONE;
		req.gpgpu = GP_NONE;
		case (opc)
			OP_R:
			begin
				req.alu_op = funct_alu;
				req.wb_src = WB_ALU;
				req.illegal = !r_ok;
			end
			OP_IMM:
			begin
				req.alu_op = funct_alu;
				req.imm_sel = 1'b1;
				req.wb_src = WB_ALU;
			end
			OP_LOAD:
			begin
				req.alu_op = ALU_ADD;
				req.imm_sel = 1'b1;
				req.wb_src = WB_MEM;
				req.is_load = 1'b1;
				req.mem_func3 = func3;
			end
			OP_STORE:
			begin
				req.alu_op = ALU_ADD;
				req.imm_sel = 1'b1;
				req.is_store = 1'b1;
				req.mem_func3 = func3;
			end
			OP_BRANCH:
			begin
				req.alu_op = ALU_SUB;
				req.branch = br_kind;
				req.illegal = (br_kind == BR_NONE);
			end
			OP_JAL:
			begin
				req.jump = 1'b1;
				req.wb_src = WB_PC4;
			end
			OP_JALR:
			begin
				req.alu_op = ALU_ADD;
				req.imm_sel = 1'b1;
				req.jump = 1'b1;
				req.jalr = 1'b1;
				req.wb_src = WB_PC4;
			end
			OP_LUI, OP_AUIPC:
			begin
				req.alu_op = (opc == OP_LUI) ? ALU_LUI : ALU_AUIPC;
				req.imm_sel = 1'b1;
				req.wb_src = WB_ALU;
			end
			OP_GPGPU:
			begin
				req.gpgpu = gp_kind;
				req.illegal = (gp_kind == GP_NONE);
			end
			default: req.illegal = 1'b1;
		endcase
		if (req.illegal)
		begin
			req.alu_op = ALU_NONE;
			req.wb_src = WB_NONE;
		end
	end

	assign stall_c = (req.branch != BR_NONE) || req.jump || (req.gpgpu == GP_TMC)
		|| (req.gpgpu == GP_SPLIT) || (req.gpgpu == GP_BARRIER);
	assign join_c = (req.gpgpu == GP_JOIN);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			dec_stb <= 1'b0;
			wstall_stb <= 1'b0;
			join_stb <= 1'b0;
		end
		else
		begin
			dec_stb <= in_stb;
			wstall_stb <= in_stb && has_lanes && stall_c;
			join_stb <= in_stb && has_lanes && join_c;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_stb)
		begin
			dec_req <= req;
			dec_ops <= in_ops;
			wstall_warp <= in_meta.warp;
			join_warp <= in_meta.warp;
		end
	end

	a_stall_join_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(wstall_stb && join_stb));

endmodule

// ==== design/int_execute.sv ====
// Execute stage: per-lane integer ALU, branch decision and jump target
`timescale 1ns/1ps
`include "warp_core_settings.svh"

module int_execute
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        dec_stb,
	input  decode_req_t dec_req,
	input  operand_t    dec_ops,
	output logic        ex_stb,
	output exec_req_t   ex_req
);

	lane_words_t alu_res_c;
	word_t       lead_rs1;
	word_t       lead_rs2;
	logic        br_taken;
	logic        taken_c;
	word_t       target_c;
	exec_req_t   req_c;

	function automatic word_t alu_calc(alu_op_e op, word_t a, word_t b);
		case (op)
			ALU_ADD, ALU_AUIPC: return a + b;
			ALU_SUB: return a - b;
			ALU_SLL: return a << b[4:0];
			ALU_SLT: return word_t'($signed(a) < $signed(b));
			ALU_SLTU: return word_t'(a < b);
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return word_t'($signed(a) >>> b[4:0]);
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			ALU_LUI: return b;
			default: return '0;
		endcase
	endfunction

	always_comb
	begin
		for (int i = 0; i < `NUM_THREADS; i++)
		begin
			alu_res_c[i] = alu_calc(dec_req.alu_op,
				(dec_req.alu_op == ALU_AUIPC) ? dec_req.pc : dec_ops.rs1[i],
				dec_req.imm_sel ? dec_req.imm : dec_ops.rs2[i]);
		end
	end

	// Lowest active lane wins, lane 0 when none is active
	always_comb
	begin
		lead_rs1 = dec_ops.rs1[0];
		lead_rs2 = dec_ops.rs2[0];
		for (int i = `NUM_THREADS - 1; i >= 0; i--)
		begin
			if (dec_req.mask[i])
			begin
				lead_rs1 = dec_ops.rs1[i];
				lead_rs2 = dec_ops.rs2[i];
			end
		end
	end

	always_comb
	begin
		case (dec_req.branch)
			BR_BEQ: br_taken = (lead_rs1 == lead_rs2);
			BR_BNE: br_taken = (lead_rs1 != lead_rs2);
			BR_BLT: br_taken = ($signed(lead_rs1) < $signed(lead_rs2));
			BR_BGE: br_taken = ($signed(lead_rs1) >= $signed(lead_rs2));
			BR_BLTU: br_taken = (lead_rs1 < lead_rs2);
			BR_BGEU: br_taken = (lead_rs1 >= lead_rs2);
			default: br_taken = 1'b0;
		endcase
	end

	assign taken_c = dec_req.jump || br_taken;
	assign target_c = dec_req.jalr ? ((lead_rs1 + dec_req.imm) & ~word_t'(1))
		: (dec_req.pc + dec_req.imm);

	always_comb
	begin
		req_c.next_pc = dec_req.next_pc;
		req_c.warp = dec_req.warp;
		req_c.mask = dec_req.mask;
		req_c.rd = dec_req.rd;
		req_c.branch = dec_req.branch;
		req_c.jump = dec_req.jump;
		req_c.wb_src = dec_req.wb_src;
		req_c.gpgpu = dec_req.gpgpu;
		req_c.illegal = dec_req.illegal;
		req_c.alu_res = alu_res_c;
		req_c.taken = taken_c;
		req_c.target = target_c;
		req_c.lead_opnd = lead_rs1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			ex_stb <= 1'b0;
		else
			ex_stb <= dec_stb;
	end

	always_ff @(posedge clk)
	begin
		if (dec_stb)
			ex_req <= req_c;
	end

	// Decode never marks an instruction as both branch and jump
	a_branch_not_jump: assert property (@(posedge clk) disable iff (!arst_n)
		dec_stb && (dec_req.branch != BR_NONE) |-> !dec_req.jump);

endmodule

// ==== design/result_route.sv ====
// Result stage with write-back and redirect records, warp control events and the stalled warp mask
`timescale 1ns/1ps
`include "warp_core_settings.svh"

module result_route
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ex_stb,
	input  exec_req_t             ex_req,
	input  logic                  wstall_stb,
	input  warp_t                 wstall_warp,
	output logic                  wb_stb,
	output wb_t                   wb,
	output logic                  redir_stb,
	output redirect_t             redir,
	output logic                  ctrl_stb,
	output warp_ctrl_t            ctrl,
	output logic [`NUM_WARPS-1:0] stalled_warps
);

	logic                  active;
	logic                  wr_c;
	logic                  redir_c;
	logic                  ctrl_c;
	lane_words_t           wb_data_c;
	logic                  clr_en;
	warp_t                 clr_warp;
	logic [`NUM_WARPS-1:0] set_mask;
	logic [`NUM_WARPS-1:0] clr_mask;

	assign active = |ex_req.mask;
	assign wr_c = active && (ex_req.wb_src != WB_NONE) && (ex_req.rd != 5'd0)
		&& !ex_req.illegal;
	assign redir_c = active && ((ex_req.branch != BR_NONE) || ex_req.jump);
	assign ctrl_c = active && ((ex_req.gpgpu == GP_TMC) || (ex_req.gpgpu == GP_WSPAWN)
		|| (ex_req.gpgpu == GP_SPLIT) || (ex_req.gpgpu == GP_BARRIER));

	always_comb
	begin
		for (int i = 0; i < `NUM_THREADS; i++)
		begin
			case (ex_req.wb_src)
				WB_ALU, WB_MEM: wb_data_c[i] = ex_req.alu_res[i];
				WB_PC4: wb_data_c[i] = ex_req.next_pc;
				default: wb_data_c[i] = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb_stb <= 1'b0;
			redir_stb <= 1'b0;
			ctrl_stb <= 1'b0;
		end
		else
		begin
			wb_stb <= ex_stb && wr_c;
			redir_stb <= ex_stb && redir_c;
			ctrl_stb <= ex_stb && ctrl_c;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ex_stb)
		begin
			wb <= '{warp: ex_req.warp, rd: ex_req.rd, data: wb_data_c, wmask: ex_req.mask};
			redir <= '{warp: ex_req.warp, taken: ex_req.taken,
				target: ex_req.taken ? ex_req.target : ex_req.next_pc};
			ctrl <= '{warp: ex_req.warp, kind: ex_req.gpgpu, mask: ex_req.mask,
				opnd: ex_req.lead_opnd};
		end
	end

	// wspawn never stalled its warp
	assign clr_en = redir_stb || (ctrl_stb && (ctrl.kind != GP_WSPAWN));
	// Every result record carries the same warp
	assign clr_warp = redir.warp;

	always_comb
	begin
		set_mask = '0;
		clr_mask = '0;
		if (wstall_stb)
			set_mask[wstall_warp] = 1'b1;
		if (clr_en)
			clr_mask[clr_warp] = 1'b1;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			stalled_warps <= '0;
		else
			stalled_warps <= (stalled_warps & ~clr_mask) | set_mask;
	end

	a_clear_was_set: assert property (@(posedge clk) disable iff (!arst_n)
		clr_en |-> stalled_warps[clr_warp]);

endmodule

// ==== design/warp_pipe_top.sv ====
// Warp pipeline top: decode, execute and result stages
`timescale 1ns/1ps
`include "warp_core_settings.svh"

module warp_pipe_top
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_stb,
	input  inst_meta_t            in_meta,
	input  operand_t              in_ops,
	output logic                  wstall_stb,
	output warp_t                 wstall_warp,
	output logic                  join_stb,
	output warp_t                 join_warp,
	output logic                  wb_stb,
	output wb_t                   wb,
	output logic                  redir_stb,
	output redirect_t             redir,
	output logic                  ctrl_stb,
	output warp_ctrl_t            ctrl,
	output logic [`NUM_WARPS-1:0] stalled_warps
);

	logic        dec_stb;
	decode_req_t dec_req;
	operand_t    dec_ops;
	logic        ex_stb;
	exec_req_t   ex_req;

	inst_decode u_decode (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_stb      (in_stb),
		.in_meta     (in_meta),
		.in_ops      (in_ops),
		.dec_stb     (dec_stb),
		.dec_req     (dec_req),
		.dec_ops     (dec_ops),
		.wstall_stb  (wstall_stb),
		.wstall_warp (wstall_warp),
		.join_stb    (join_stb),
		.join_warp   (join_warp)
	);

	int_execute u_execute (
		.clk     (clk),
		.arst_n  (arst_n),
		.dec_stb (dec_stb),
		.dec_req (dec_req),
		.dec_ops (dec_ops),
		.ex_stb  (ex_stb),
		.ex_req  (ex_req)
	);

	// Stall set comes straight from decode
	result_route u_result (
		.clk           (clk),
		.arst_n        (arst_n),
		.ex_stb        (ex_stb),
		.ex_req        (ex_req),
		.wstall_stb    (wstall_stb),
		.wstall_warp   (wstall_warp),
		.wb_stb        (wb_stb),
		.wb            (wb),
		.redir_stb     (redir_stb),
		.redir         (redir),
		.ctrl_stb      (ctrl_stb),
		.ctrl          (ctrl),
		.stalled_warps (stalled_warps)
	);

endmodule

// ==== dv/tb_ref_model.svh ====
// Instruction encoders, expected result record and reference model of the warp pipeline
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
	warp_t      warp;
	logic       wstall;
	logic       is_join;
	logic       wb_en;
	wb_t        wb;
	logic       redir_en;
	redirect_t  redir;
	logic       ctrl_en;
	warp_ctrl_t ctrl;
} expect_t;

function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
	logic [4:0] rs1, logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t enc_i(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
	logic [4:0] rs1, logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
	logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic word_t enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
	logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic word_t enc_u(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
	return {imm, rd, op};
endfunction

function automatic word_t enc_j(logic [4:0] rd, logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// RV32I integer result, alt selects SUB or SRA
function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
	case (f3)
		3'd0: return alt ? a - b : a + b;
		3'd1: return a << b[4:0];
		3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		3'd3: return (a < b) ? 32'd1 : 32'd0;
		3'd4: return a ^ b;
		3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
		3'd6: return a | b;
		default: return a & b;
	endcase
endfunction

function automatic expect_t predict(inst_meta_t m, operand_t o);
	expect_t    e;
	word_t      in;
	logic [6:0] op;
	logic [2:0] f3;
	word_t      imm_i;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	word_t      la;
	word_t      lb;
	logic       legal;
	logic       writes;
	logic       take;
	int         lead;
	e = '0;
	in = m.instr;
	op = in[6:0];
	f3 = in[14:12];
	imm_i = {{20{in[31]}}, in[31:20]};
	imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
	imm_u = {in[31:12], 12'b0};
	imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
	lead = 0;
	for (int i = `NUM_THREADS - 1; i >= 0; i--)
		if (m.mask[i])
			lead = i;
	la = o.rs1[lead];
	lb = o.rs2[lead];
	legal = 1'b1;
	writes = 1'b0;
	take = 1'b0;
	e.warp = m.warp;
	e.wb.warp = m.warp;
	e.wb.rd = in[11:7];
	e.wb.wmask = m.mask;
	e.redir.warp = m.warp;
	e.ctrl = '{warp: m.warp, kind: GP_NONE, mask: m.mask, opnd: la};
	case (op)
		7'b0110011:
		begin
			legal = (in[31:25] == 7'h00)
				|| ((in[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
			writes = 1'b1;
			for (int i = 0; i < `NUM_THREADS; i++)
				e.wb.data[i] = alu_ref(f3, in[30], o.rs1[i], o.rs2[i]);
		end
		7'b0010011:
		begin
			writes = 1'b1;
			for (int i = 0; i < `NUM_THREADS; i++)
				e.wb.data[i] = alu_ref(f3, in[30] && (f3 == 3'd5), o.rs1[i],
					((f3 == 3'd1) || (f3 == 3'd5)) ? word_t'(in[24:20]) : imm_i);
		end
		// Load gives its address only
		7'b0000011:
		begin
			writes = 1'b1;
			for (int i = 0; i < `NUM_THREADS; i++)
				e.wb.data[i] = o.rs1[i] + imm_i;
		end
		7'b0100011:
			writes = 1'b0;
		7'b0110111, 7'b0010111:
		begin
			writes = 1'b1;
			for (int i = 0; i < `NUM_THREADS; i++)
				e.wb.data[i] = (op == 7'b0110111) ? imm_u : m.pc + imm_u;
		end
		7'b1100011:
		begin
			case (f3)
				3'd0: take = (la == lb);
				3'd1: take = (la != lb);
				3'd4: take = ($signed(la) < $signed(lb));
				3'd5: take = ($signed(la) >= $signed(lb));
				3'd6: take = (la < lb);
				3'd7: take = (la >= lb);
				default: legal = 1'b0;
			endcase
			e.wstall = 1'b1;
			e.redir_en = 1'b1;
			e.redir.taken = take;
			e.redir.target = take ? m.pc + imm_b : m.pc + 32'd4;
		end
		7'b1101111, 7'b1100111:
		begin
			writes = 1'b1;
			for (int i = 0; i < `NUM_THREADS; i++)
				e.wb.data[i] = m.pc + 32'd4;
			e.wstall = 1'b1;
			e.redir_en = 1'b1;
			e.redir.taken = 1'b1;
			e.redir.target = (op == 7'b1101111) ? m.pc + imm_j : (la + imm_i) & ~32'd1;
		end
		7'b1101011:
		begin
			case (f3)
				3'd0: e.ctrl.kind = GP_TMC;
				3'd1: e.ctrl.kind = GP_WSPAWN;
				3'd2: e.ctrl.kind = GP_SPLIT;
				3'd3: e.ctrl.kind = GP_JOIN;
				3'd4: e.ctrl.kind = GP_BARRIER;
				default: legal = 1'b0;
			endcase
			e.is_join = (f3 == 3'd3);
			e.ctrl_en = (f3 <= 3'd4) && !e.is_join;
			e.wstall = (f3 == 3'd0) || (f3 == 3'd2) || (f3 == 3'd4);
		end
		// SYSTEM and unknown opcodes
		default:
			legal = 1'b0;
	endcase
	e.wb_en = writes && (e.wb.rd != 5'd0);
	if (!legal || (m.mask == '0))
	begin
		e.wstall = 1'b0;
		e.is_join = 1'b0;
		e.wb_en = 1'b0;
		e.redir_en = 1'b0;
		e.ctrl_en = 1'b0;
	end
	return e;
endfunction

`endif

// ==== dv/tb_top.sv ====
// Testbench for the warp pipeline: clock, reset, stimulus, compare process and check task
`timescale 1ns/1ps
`include "warp_core_settings.svh"

module tb_top
	import isa_pkg::*;
	import pipe_pkg::*;
();

	`include "tb_ref_model.svh"

	typedef struct packed {
		logic [31:0] cyc;
		expect_t     e;
	} sent_t;

	logic                  clk;
	logic                  arst_n;
	logic                  in_stb;
	inst_meta_t            in_meta;
	operand_t              in_ops;
	logic                  wstall_stb;
	warp_t                 wstall_warp;
	logic                  join_stb;
	warp_t                 join_warp;
	logic                  wb_stb;
	wb_t                   wb;
	logic                  redir_stb;
	redirect_t             redir;
	logic                  ctrl_stb;
	warp_ctrl_t            ctrl;
	logic [`NUM_WARPS-1:0] stalled_warps;
	logic [31:0]           cyc;
	logic [`NUM_WARPS-1:0] exp_stalled;
	warp_t                 rot_warp;
	int                    errors;
	sent_t                 sent_q[$];

	warp_pipe_top u_dut (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_stb        (in_stb),
		.in_meta       (in_meta),
		.in_ops        (in_ops),
		.wstall_stb    (wstall_stb),
		.wstall_warp   (wstall_warp),
		.join_stb      (join_stb),
		.join_warp     (join_warp),
		.wb_stb        (wb_stb),
		.wb            (wb),
		.redir_stb     (redir_stb),
		.redir         (redir),
		.ctrl_stb      (ctrl_stb),
		.ctrl          (ctrl),
		.stalled_warps (stalled_warps)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function automatic tmask_t rand_mask();
		return tmask_t'($urandom_range((1 << `NUM_THREADS) - 1, 1));
	endfunction

	task automatic send(input word_t instr, input warp_t warp, input tmask_t mask);
		inst_meta_t m;
		operand_t   o;
		m.instr = instr;
		m.pc = $urandom & 32'hffff_fffc;
		m.warp = warp;
		m.mask = mask;
		for (int i = 0; i < `NUM_THREADS; i++)
		begin
			o.rs1[i] = $urandom;
			// Equal operands now and then so equality branches get taken
			o.rs2[i] = ($urandom_range(3) == 0) ? o.rs1[i] : $urandom;
		end
		@(negedge clk);
		in_stb = 1'b1;
		in_meta = m;
		in_ops = o;
		sent_q.push_back('{cyc: cyc, e: predict(m, o)});
	endtask

	// Warps in turn, so a warp never has two stalls in flight
	task automatic send_rotating(input word_t instr);
		send(instr, rot_warp, rand_mask());
		rot_warp = (rot_warp == warp_t'(`NUM_WARPS - 1)) ? '0 : rot_warp + 1'b1;
	endtask

	task automatic drain();
		int waited;
		@(negedge clk);
		in_stb = 1'b0;
		waited = 0;
		while (sent_q.size() != 0)
		begin
			if (waited == 50)
			begin
				$display("Timeout: the pipeline did not retire all instructions");
				$display("TEST FAILED");
				$fatal(1, "no progress in the pipeline");
			end
			waited++;
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	// Compare process: decode strobes at send + 1, result strobes at send + 3
	always @(negedge clk)
	begin
		expect_t de;
		expect_t re;
		de = '0;
		re = '0;
		foreach (sent_q[k])
		begin
			if (sent_q[k].cyc + 1 == cyc)
				de = sent_q[k].e;
			if (sent_q[k].cyc + 3 == cyc)
				re = sent_q[k].e;
		end
		compare_value("wstall_stb", wstall_stb, de.wstall);
		compare_value("join_stb", join_stb, de.is_join);
		if (wstall_stb)
			compare_value("wstall_warp", wstall_warp, de.warp);
		if (join_stb)
			compare_value("join_warp", join_warp, de.warp);
		compare_value("wb_stb", wb_stb, re.wb_en);
		if (wb_stb)
		begin
			compare_value("wb.warp", wb.warp, re.wb.warp);
			compare_value("wb.rd", wb.rd, re.wb.rd);
			compare_value("wb.wmask", wb.wmask, re.wb.wmask);
			for (int i = 0; i < `NUM_THREADS; i++)
				if (re.wb.wmask[i])
					compare_value($sformatf("wb.data[%0d]", i), wb.data[i], re.wb.data[i]);
		end
		compare_value("redir_stb", redir_stb, re.redir_en);
		if (redir_stb)
		begin
			compare_value("redir.warp", redir.warp, re.redir.warp);
			compare_value("redir.taken", redir.taken, re.redir.taken);
			compare_value("redir.target", redir.target, re.redir.target);
		end
		compare_value("ctrl_stb", ctrl_stb, re.ctrl_en);
		if (ctrl_stb)
		begin
			compare_value("ctrl.warp", ctrl.warp, re.ctrl.warp);
			compare_value("ctrl.kind", ctrl.kind, re.ctrl.kind);
			compare_value("ctrl.mask", ctrl.mask, re.ctrl.mask);
			compare_value("ctrl.opnd", ctrl.opnd, re.ctrl.opnd);
		end
		compare_value("stalled_warps", stalled_warps, exp_stalled);
		// Stall bits follow the strobes by one cycle
		if (re.wstall)
			exp_stalled[re.warp] = 1'b0;
		if (de.wstall)
			exp_stalled[de.warp] = 1'b1;
		if ((sent_q.size() != 0) && (sent_q[0].cyc + 3 <= cyc))
			void'(sent_q.pop_front());
	end

	initial
	begin
		logic [2:0] f3;
		logic       alt;
		logic [4:0] rd;
		void'($urandom(32'hbeda));
		clk = 1'b0;
		arst_n = 1'b0;
		in_stb = 1'b0;
		in_meta = '0;
		in_ops = '0;
		cyc = '0;
		exp_stalled = '0;
		rot_warp = '0;
		errors = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Register and immediate ALU ops, back to back
		repeat (40)
		begin
			f3 = 3'($urandom);
			alt = ($urandom_range(1) == 1) && ((f3 == 3'd0) || (f3 == 3'd5));
			rd = ($urandom_range(7) == 0) ? 5'd0 : 5'($urandom);
			if ($urandom_range(1) == 1)
				send(enc_r(alt ? 7'h20 : 7'h00, f3, rd, 5'($urandom), 5'($urandom)),
					warp_t'($urandom), rand_mask());
			else
				send(enc_i(7'b0010011, f3, rd, 5'($urandom),
					((f3 == 3'd1) || (f3 == 3'd5)) ? {1'b0, alt, 5'b0, 5'($urandom)}
					: 12'($urandom)), warp_t'($urandom), rand_mask());
		end
		drain();

		// LUI, AUIPC, load and store address
		repeat (6)
		begin
			send(enc_u(7'b0110111, 5'($urandom), 20'($urandom)), warp_t'($urandom), rand_mask());
			send(enc_u(7'b0010111, 5'($urandom), 20'($urandom)), warp_t'($urandom), rand_mask());
			send(enc_i(7'b0000011, 3'd2, 5'($urandom), 5'($urandom), 12'($urandom)),
				warp_t'($urandom), rand_mask());
			send(enc_s(3'd2, 5'($urandom), 5'($urandom), 12'($urandom)),
				warp_t'($urandom), rand_mask());
		end
		drain();

		// All six branch kinds, then JAL and JALR
		for (int k = 0; k < 24; k++)
		begin
			f3 = 3'(k % 6);
			if (f3 >= 3'd2)
				f3 = f3 + 3'd2;
			send_rotating(enc_b(f3, 5'($urandom), 5'($urandom), 13'($urandom) & 13'h1ffe));
		end
		repeat (4)
		begin
			send_rotating(enc_j(5'($urandom), 21'($urandom) & ~21'd1));
			send_rotating(enc_i(7'b1100111, 3'd0, 5'($urandom), 5'($urandom), 12'($urandom)));
		end
		drain();

		// tmc, wspawn, split, join, barrier
		repeat (4)
			for (int k = 0; k <= 4; k++)
				send_rotating(enc_i(7'b1101011, 3'(k), 5'd0, 5'($urandom), 12'd0));
		drain();

		// Illegal encodings: ecall, csrrw, custom-0, mul, branch func3 2, GPGPU func3 6
		send_rotating(enc_i(7'b1110011, 3'd0, 5'd0, 5'd0, 12'd0));
		send_rotating(enc_i(7'b1110011, 3'd1, 5'd3, 5'd4, 12'h300));
		send_rotating(enc_i(7'b0001011, 3'd0, 5'd5, 5'd6, 12'd7));
		send_rotating(enc_r(7'h01, 3'd0, 5'd7, 5'd8, 5'd9));
		send_rotating(enc_b(3'd2, 5'd1, 5'd2, 13'd16));
		send_rotating(enc_i(7'b1101011, 3'd6, 5'd0, 5'd1, 12'd0));
		// Empty thread masks
		send(enc_r(7'h00, 3'd0, 5'd1, 5'd2, 5'd3), warp_t'($urandom), '0);
		send(enc_b(3'd0, 5'd1, 5'd1, 13'd8), warp_t'($urandom), '0);
		send(enc_j(5'd1, 21'd64), warp_t'($urandom), '0);
		send(enc_i(7'b1101011, 3'd0, 5'd0, 5'd1, 12'd0), warp_t'($urandom), '0);
		send(enc_i(7'b1101011, 3'd3, 5'd0, 5'd1, 12'd0), warp_t'($urandom), '0);
		drain();

		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+design
+incdir+dv
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_decode.sv
design/int_execute.sv
design/result_route.sv
design/warp_pipe_top.sv
dv/tb_top.sv
